// ==== Bender.yml ====
package:
  name: ultrasound_pwm

sources:
  - hdl/bus_pkg.sv
  - hdl/mod_pkg.sv
  - hdl/memory_bus_if.sv
  - hdl/controller_regs.sv
  - hdl/mod_sampler.sv
  - hdl/intensity_scaler.sv
  - hdl/pulse_width_encoder.sv
  - hdl/pwm_generator.sv
  - hdl/ultrasound_top.sv
  - target: test
    files:
      - bench/sim_helper_bram.sv
      - bench/tb_top.sv

// ==== bench/mod_testdata.txt ====
// hex words placed by @ address: settings, read-back patterns, samples, expected widths
// settings: cycle, freq_div fast, freq_div slow, intensity full, intensity half, duty offset
@00
000f 0001 0003 00ff 0080 0010
// read-back patterns: ctl flag, cycle, freq_div, intensity
@08
0001 01a5 beef 005a
// modulation samples 0 to 15
@10
0000 0010 0020 0040 0080 00ff 00c0 0001
0002 007f 0033 00e0 0008 0090 0055 00aa
// expected pulse widths at full intensity
@20
0000 001f 002f 004f 008f 000e 00cf 0000
0011 008e 0042 00ef 0017 009f 0064 00b9

// ==== bench/sim_helper_bram.sv ====
`timescale 1ns/1ps
module sim_helper_bram (
  memory_bus_if.controller bus
);

  // inputs change this long after the rising edge
  localparam int DRIVE_DELAY = 1;
  // a write is repeated on this many edges
  localparam int WRITE_EDGES = 2;

  initial begin
    bus.en = 1'b0;
    bus.we = 1'b0;
    bus.bram_select = bus_pkg::SELECT_CONTROLLER;
    bus.bram_addr = '0;
    bus.data_in = '0;
  end

  task automatic drive_idle();
    bus.en = 1'b0;
    bus.we = 1'b0;
    bus.data_in = '0;
  endtask

  task automatic bram_write(
    input bus_pkg::bram_select_t select,
    input logic [bus_pkg::BUS_ADDR_WIDTH-1:0] addr,
    input logic [bus_pkg::BUS_DATA_WIDTH-1:0] data
  );
    @(posedge bus.CPU_CKIO);
    #(DRIVE_DELAY);
    bus.en = 1'b1;
    bus.we = 1'b1;
    bus.bram_select = select;
    bus.bram_addr = addr;
    bus.data_in = data;
    repeat (WRITE_EDGES) @(posedge bus.CPU_CKIO);
    #(DRIVE_DELAY);
    drive_idle();
  endtask

  task automatic bram_read(
    input bus_pkg::bram_select_t select,
    input logic [bus_pkg::BUS_ADDR_WIDTH-1:0] addr,
    output logic [bus_pkg::BUS_DATA_WIDTH-1:0] data
  );
    @(posedge bus.CPU_CKIO);
    #(DRIVE_DELAY);
    bus.en = 1'b1;
    bus.we = 1'b0;
    bus.bram_select = select;
    bus.bram_addr = addr;
    // data_out is loaded on this edge and holds afterwards
    @(posedge bus.CPU_CKIO);
    #(DRIVE_DELAY);
    drive_idle();
    data = bus.data_out;
  endtask

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps
module tb_top;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_SAMPLES = 16;
  localparam int SEQ_PERIODS = 20;
  localparam int DIV_SAMPLES = 4;
  // setup, three reconfigurations of three periods, the checked periods, the stop
  localparam int TOTAL_PERIODS = 3 + 3 * 3 + SEQ_PERIODS + 3 * DIV_SAMPLES + NUM_SAMPLES + 1 + 3;
  localparam int CYCLE_LIMIT = TOTAL_PERIODS * mod_pkg::CARRIER_PERIOD * 6 / 5;

  // word positions in the test data file
  localparam int IDX_CYCLE = 0;
  localparam int IDX_DIV_FAST = 1;
  localparam int IDX_DIV_SLOW = 2;
  localparam int IDX_INT_FULL = 3;
  localparam int IDX_INT_HALF = 4;
  localparam int IDX_DUTY_OFFSET = 5;
  localparam int IDX_READBACK = 8;
  localparam int IDX_SAMPLES = 16;
  localparam int IDX_EXPECTED = 32;

  logic CPU_CKIO;
  logic rst_n;
  logic sync;
  logic pwm_out;
  int checks_done;
  int cycle_count;
  logic [15:0] test_words[0:47];
  logic [7:0] samples[NUM_SAMPLES];
  logic [7:0] expected_widths[NUM_SAMPLES];
  logic [7:0] duty_table[256];

  memory_bus_if bus (.CPU_CKIO(CPU_CKIO));

  sim_helper_bram bram_driver (.bus(bus));

  ultrasound_top dut (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .bus(bus),
    .sync(sync),
    .pwm_out(pwm_out)
  );

  always #2 CPU_CKIO = ~CPU_CKIO;

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge CPU_CKIO);
      cycle_count++;
    end
    $display("timeout after %0d clock cycles, the test sequence did not finish", cycle_count);
    $display("Something failed");
    $fatal(1);
  end

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks_done++;
    if (actual !== expected) begin
      $display("Fail %s expected %0h actual %0h", name, expected, actual);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_reg(input string name, input bus_pkg::bram_select_t select,
                           input logic [13:0] addr, input logic [15:0] expected);
    logic [15:0] data;
    bram_driver.bram_read(select, addr, data);
    check_value(name, expected, data);
  endtask

  // width rule: duty entry of the upper byte of sample times intensity, zero stays zero
  function automatic logic [7:0] expected_width(input logic [7:0] sample,
                                                input logic [7:0] intensity);
    logic [15:0] product;
    product = sample * intensity;
    if (product[15:8] == 8'd0) return 8'd0;
    return duty_table[product[15:8]];
  endfunction

  task automatic wait_sync();
    @(negedge CPU_CKIO);
    while (!sync) @(negedge CPU_CKIO);
  endtask

  // high time of pwm_out up to the next sync, started right after a sync
  task automatic measure_period(output int high_cycles);
    int period_cycles;
    high_cycles = 0;
    period_cycles = 0;
    @(negedge CPU_CKIO);
    while (!sync) begin
      if (pwm_out) high_cycles++;
      period_cycles++;
      @(negedge CPU_CKIO);
    end
    // sync takes the last cycle of each carrier period
    check_value("sync spacing", 16'(mod_pkg::CARRIER_PERIOD - 1), 16'(period_cycles));
  endtask

  task automatic start_modulation(input logic [15:0] freq_div, input logic [15:0] intensity);
    int skipped;
    wait_sync();
    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_CTL_FLAG, 16'h0000);
    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_MOD_CYCLE,
                           test_words[IDX_CYCLE]);
    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_MOD_FREQ_DIV, freq_div);
    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_INTENSITY, intensity);
    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_CTL_FLAG, 16'h0001);
    // sample 0 is fetched at this sync and shows one period later
    wait_sync();
    measure_period(skipped);
  endtask

  task automatic check_widths(input string name, input logic [7:0] intensity,
                              input int repeat_n, input int periods);
    int high_cycles;
    int idx;
    for (int p = 0; p < periods; p++) begin
      idx = (p / repeat_n) % NUM_SAMPLES;
      measure_period(high_cycles);
      check_value($sformatf("%s period %0d", name, p),
                  16'(expected_width(samples[idx], intensity)), 16'(high_cycles));
    end
  endtask

  initial begin
    int high_cycles;
    CPU_CKIO = 1'b0;
    rst_n = 1'b0;
    checks_done = 0;
    $readmemh("bench/mod_testdata.txt", test_words);
    for (int i = 0; i < NUM_SAMPLES; i++) begin
      samples[i] = test_words[IDX_SAMPLES + i][7:0];
      expected_widths[i] = test_words[IDX_EXPECTED + i][7:0];
    end
    for (int i = 0; i < 256; i++) begin
      duty_table[i] = 8'(i) + test_words[IDX_DUTY_OFFSET][7:0];
    end

    @(posedge CPU_CKIO);
    repeat (RESET_CYCLES - 1) begin
      @(negedge CPU_CKIO);
      check_value("reset pwm_out", 16'h0, 16'(pwm_out));
      check_value("reset sync", 16'h0, 16'(sync));
      @(posedge CPU_CKIO);
    end
    #1;
    rst_n = 1'b1;
    repeat (8) begin
      @(negedge CPU_CKIO);
      check_value("after reset pwm_out", 16'h0, 16'(pwm_out));
      check_value("after reset sync", 16'h0, 16'(sync));
    end
    check_reg("reset ctl flag", bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_CTL_FLAG, 16'h0);
    check_reg("reset cycle", bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_MOD_CYCLE, 16'h0);
    check_reg("reset freq_div", bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_MOD_FREQ_DIV, 16'h1);
    check_reg("reset intensity", bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_INTENSITY, 16'h0);

    for (int w = 0; w < NUM_SAMPLES / 2; w++) begin
      bram_driver.bram_write(bus_pkg::SELECT_MOD, 14'(w), {samples[2*w+1], samples[2*w]});
    end
    for (int w = 0; w < 128; w++) begin
      bram_driver.bram_write(bus_pkg::SELECT_DUTY_TABLE, 14'(w),
                             {duty_table[2*w+1], duty_table[2*w]});
    end
    for (int i = 0; i < NUM_SAMPLES; i++) begin
      check_value($sformatf("expected list %0d", i), 16'(expected_widths[i]),
                  16'(expected_width(samples[i], test_words[IDX_INT_FULL][7:0])));
    end

    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_CTL_FLAG,
                           test_words[IDX_READBACK]);
    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_MOD_CYCLE,
                           test_words[IDX_READBACK + 1]);
    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_MOD_FREQ_DIV,
                           test_words[IDX_READBACK + 2]);
    bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_INTENSITY,
                           test_words[IDX_READBACK + 3]);
    check_reg("readback ctl flag", bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_CTL_FLAG,
              test_words[IDX_READBACK]);
    check_reg("readback cycle", bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_MOD_CYCLE,
              test_words[IDX_READBACK + 1]);
    check_reg("readback freq_div", bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_MOD_FREQ_DIV,
              test_words[IDX_READBACK + 2]);
    check_reg("readback intensity", bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_INTENSITY,
              test_words[IDX_READBACK + 3]);
    check_reg("mod select read", bus_pkg::SELECT_MOD, 14'h0, 16'h0);

    start_modulation(test_words[IDX_DIV_FAST], test_words[IDX_INT_FULL]);
    check_widths("sequence", test_words[IDX_INT_FULL][7:0], 1, SEQ_PERIODS);
    start_modulation(test_words[IDX_DIV_SLOW], test_words[IDX_INT_FULL]);
    check_widths("divider", test_words[IDX_INT_FULL][7:0], int'(test_words[IDX_DIV_SLOW]),
                 int'(test_words[IDX_DIV_SLOW]) * DIV_SAMPLES);
    start_modulation(test_words[IDX_DIV_FAST], test_words[IDX_INT_HALF]);
    check_widths("intensity", test_words[IDX_INT_HALF][7:0], 1, NUM_SAMPLES + 1);

    // sample 1 is already latched for this period when enable drops
    fork
      bram_driver.bram_write(bus_pkg::SELECT_CONTROLLER, bus_pkg::ADDR_CTL_FLAG, 16'h0000);
      measure_period(high_cycles);
    join
    check_value("stop last width",
                16'(expected_width(samples[1], test_words[IDX_INT_HALF][7:0])),
                16'(high_cycles));
    for (int p = 0; p < 2; p++) begin
      measure_period(high_cycles);
      check_value($sformatf("stop period %0d", p), 16'h0, 16'(high_cycles));
    end

    if (checks_done == 0) begin
      $display("no checks were run");
      $display("Something failed");
      $fatal(1);
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

  localparam int BUS_ADDR_WIDTH = 14;
  localparam int BUS_DATA_WIDTH = 16;
  localparam int BUS_SELECT_WIDTH = 2;

  // upper two bits of the cpu word address pick the target
  typedef enum logic [BUS_SELECT_WIDTH-1:0] {
    SELECT_CONTROLLER = 2'b00,
    SELECT_MOD        = 2'b01,
    SELECT_DUTY_TABLE = 2'b10
  } bram_select_t;

  // controller register map, word addresses
  typedef enum logic [BUS_ADDR_WIDTH-1:0] {
    ADDR_CTL_FLAG     = 14'h0000,
    ADDR_MOD_CYCLE    = 14'h0001,
    ADDR_MOD_FREQ_DIV = 14'h0002,
    ADDR_INTENSITY    = 14'h0003
  } reg_addr_t;

  // bit positions inside ADDR_CTL_FLAG
  localparam int CTL_FLAG_MOD_EN_BIT = 0;

  // freq_div comes out of reset at one period per sample
  localparam logic [BUS_DATA_WIDTH-1:0] FREQ_DIV_RESET = 16'd1;

endpackage

// ==== hdl/controller_regs.sv ====
`timescale 1ns/1ps
module controller_regs (
  input logic CPU_CKIO,
  input logic rst_n,
  memory_bus_if.target bus,
  output mod_pkg::mod_settings_t settings
);

  logic wr_en;
  logic rd_en;
  logic ctl_sel;
  bus_pkg::reg_addr_t reg_addr;
  logic [bus_pkg::BUS_DATA_WIDTH-1:0] rd_data;

  assign ctl_sel = bus.bram_select == bus_pkg::SELECT_CONTROLLER;
  assign wr_en = bus.en && bus.we && ctl_sel;
  assign rd_en = bus.en && !bus.we;
  assign reg_addr = bus_pkg::reg_addr_t'(bus.bram_addr);

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      settings.enable <= 1'b0;
      settings.cycle <= '0;
      settings.freq_div <= bus_pkg::FREQ_DIV_RESET;
      settings.intensity <= '0;
    end else if (wr_en) begin
      case (reg_addr)
        bus_pkg::ADDR_CTL_FLAG: begin
          settings.enable <= bus.data_in[bus_pkg::CTL_FLAG_MOD_EN_BIT];
        end
        bus_pkg::ADDR_MOD_CYCLE: begin
          settings.cycle <= bus.data_in[mod_pkg::MOD_ADDR_WIDTH-1:0];
        end
        bus_pkg::ADDR_MOD_FREQ_DIV: begin
          settings.freq_div <= bus.data_in[mod_pkg::FREQ_DIV_WIDTH-1:0];
        end
        bus_pkg::ADDR_INTENSITY: begin
          settings.intensity <= bus.data_in[mod_pkg::SAMPLE_WIDTH-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // zero-extended view of the addressed register
  always_comb begin
    rd_data = '0;
    case (reg_addr)
      bus_pkg::ADDR_CTL_FLAG: begin
        rd_data[bus_pkg::CTL_FLAG_MOD_EN_BIT] = settings.enable;
      end
      bus_pkg::ADDR_MOD_CYCLE: begin
        rd_data[mod_pkg::MOD_ADDR_WIDTH-1:0] = settings.cycle;
      end
      bus_pkg::ADDR_MOD_FREQ_DIV: begin
        rd_data[mod_pkg::FREQ_DIV_WIDTH-1:0] = settings.freq_div;
      end
      bus_pkg::ADDR_INTENSITY: begin
        rd_data[mod_pkg::SAMPLE_WIDTH-1:0] = settings.intensity;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // read data shows up one cycle after the read strobe and holds
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      bus.data_out <= '0;
    end else if (rd_en) begin
      // memories behind the other selects are write only
      bus.data_out <= ctl_sel ? rd_data : '0;
    end
  end

endmodule

// ==== hdl/intensity_scaler.sv ====
`timescale 1ns/1ps
module intensity_scaler (
  input logic CPU_CKIO,
  input logic rst_n,
  input mod_pkg::mod_settings_t settings,
  input mod_pkg::sample_t sample_in,
  output mod_pkg::sample_t sample_out
);

  logic [2*mod_pkg::SAMPLE_WIDTH-1:0] product;

  assign product = sample_in.value * settings.intensity;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      sample_out.valid <= 1'b0;
    end else begin
      sample_out.valid <= sample_in.valid;
    end
  end

  // keep the upper byte, 255 x 255 lands on 254
  always_ff @(posedge CPU_CKIO) begin
    if (sample_in.valid) begin
      sample_out.value <= product[2*mod_pkg::SAMPLE_WIDTH-1:mod_pkg::SAMPLE_WIDTH];
    end
  end

endmodule

// ==== hdl/memory_bus_if.sv ====
`timescale 1ns/1ps
interface memory_bus_if (
  input logic CPU_CKIO
);
  logic en;
  logic we;
  bus_pkg::bram_select_t bram_select;
  logic [bus_pkg::BUS_ADDR_WIDTH-1:0] bram_addr;
  logic [bus_pkg::BUS_DATA_WIDTH-1:0] data_in;
  logic [bus_pkg::BUS_DATA_WIDTH-1:0] data_out;

  modport controller(
    input CPU_CKIO, data_out,
    output en, we, bram_select, bram_addr, data_in
  );

  modport target(input CPU_CKIO, en, we, bram_select, bram_addr, data_in, output data_out);
endinterface

// ==== hdl/mod_pkg.sv ====
package mod_pkg;

  localparam int SAMPLE_WIDTH = 8;
  localparam int MOD_DEPTH = 512;
  localparam int MOD_ADDR_WIDTH = 9;
  localparam int MOD_WORD_ADDR_WIDTH = 8;
  localparam int DUTY_WORDS = 128;
  localparam int DUTY_WORD_ADDR_WIDTH = 7;
  localparam int FREQ_DIV_WIDTH = 16;
  localparam int CARRIER_PERIOD = 256;
  localparam int CARRIER_WIDTH = 8;
  localparam logic [CARRIER_WIDTH-1:0] CARRIER_LAST = CARRIER_WIDTH'(CARRIER_PERIOD - 1);

  typedef struct packed {
    logic                      enable;
    logic [MOD_ADDR_WIDTH-1:0] cycle;
    logic [FREQ_DIV_WIDTH-1:0] freq_div;
    logic [SAMPLE_WIDTH-1:0]   intensity;
  } mod_settings_t;

  typedef struct packed {
    logic                    valid;
    logic [SAMPLE_WIDTH-1:0] value;
  } sample_t;

  typedef enum logic {IDLE, RUN} sampler_state_t;

endpackage

// ==== hdl/mod_sampler.sv ====
`timescale 1ns/1ps
module mod_sampler (
  input logic CPU_CKIO,
  input logic rst_n,
  memory_bus_if.target bus,
  input mod_pkg::mod_settings_t settings,
  input logic period_start,
  output mod_pkg::sample_t sample
);

  // two samples per word, low byte holds the even index
  logic [bus_pkg::BUS_DATA_WIDTH-1:0] mod_mem[mod_pkg::MOD_DEPTH/2];

  mod_pkg::sampler_state_t state;
  logic [mod_pkg::MOD_ADDR_WIDTH-1:0] idx;
  logic [mod_pkg::FREQ_DIV_WIDTH-1:0] period_cnt;
  logic [mod_pkg::FREQ_DIV_WIDTH-1:0] last_period;
  logic [bus_pkg::BUS_DATA_WIDTH-1:0] mem_word;
  logic [mod_pkg::SAMPLE_WIDTH-1:0] mem_byte;
  logic mod_wr_en;

  assign mod_wr_en = bus.en && bus.we && (bus.bram_select == bus_pkg::SELECT_MOD);

  always_ff @(posedge CPU_CKIO) begin
    if (mod_wr_en) begin
      mod_mem[bus.bram_addr[mod_pkg::MOD_WORD_ADDR_WIDTH-1:0]] <= bus.data_in;
    end
  end

  assign mem_word = mod_mem[idx[mod_pkg::MOD_ADDR_WIDTH-1:1]];
  assign mem_byte = idx[0] ? mem_word[15:8] : mem_word[7:0];

  // a divider of zero behaves like one
  assign last_period = (settings.freq_div == '0) ? '0 : settings.freq_div - 1'b1;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      state <= mod_pkg::IDLE;
      idx <= '0;
      period_cnt <= '0;
      sample.valid <= 1'b0;
    end else begin
      sample.valid <= 1'b0;
      case (state)
        mod_pkg::IDLE: begin
          idx <= '0;
          period_cnt <= '0;
          if (settings.enable) state <= mod_pkg::RUN;
        end
        mod_pkg::RUN: begin
          if (!settings.enable) begin
            // closing zero sample so the output falls silent
            state <= mod_pkg::IDLE;
            sample.valid <= 1'b1;
            sample.value <= '0;
          end else if (period_start) begin
            if (period_cnt == '0) begin
              sample.valid <= 1'b1;
              sample.value <= mem_byte;
              idx <= (idx >= settings.cycle) ? '0 : idx + 1'b1;
            end
            period_cnt <= (period_cnt >= last_period) ? '0 : period_cnt + 1'b1;
          end
        end
        default: begin
          state <= mod_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== hdl/pulse_width_encoder.sv ====
`timescale 1ns/1ps
module pulse_width_encoder (
  input logic CPU_CKIO,
  input logic rst_n,
  memory_bus_if.target bus,
  input mod_pkg::sample_t sample_in,
  output mod_pkg::sample_t width
);

  // 256 duty entries packed two per word
  logic [bus_pkg::BUS_DATA_WIDTH-1:0] duty_mem[mod_pkg::DUTY_WORDS];

  logic duty_wr_en;
  logic [bus_pkg::BUS_DATA_WIDTH-1:0] word_q;
  logic byte_sel_q;
  logic zero_q;
  logic valid_q;

  assign duty_wr_en = bus.en && bus.we && (bus.bram_select == bus_pkg::SELECT_DUTY_TABLE);

  always_ff @(posedge CPU_CKIO) begin
    if (duty_wr_en) begin
      duty_mem[bus.bram_addr[mod_pkg::DUTY_WORD_ADDR_WIDTH-1:0]] <= bus.data_in;
    end
  end

  // table read stage
  always_ff @(posedge CPU_CKIO) begin
    if (sample_in.valid) begin
      word_q <= duty_mem[sample_in.value[mod_pkg::SAMPLE_WIDTH-1:1]];
      byte_sel_q <= sample_in.value[0];
      zero_q <= sample_in.value == '0;
    end
  end

  // output stage; zero amplitude always means no pulse
  always_ff @(posedge CPU_CKIO) begin
    if (valid_q) begin
      if (zero_q) begin
        width.value <= '0;
      end else begin
        width.value <= byte_sel_q ? word_q[15:8] : word_q[7:0];
      end
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      width.valid <= 1'b0;
    end else begin
      valid_q <= sample_in.valid;
      width.valid <= valid_q;
    end
  end

endmodule

// ==== hdl/pwm_generator.sv ====
`timescale 1ns/1ps
module pwm_generator (
  input logic CPU_CKIO,
  input logic rst_n,
  input mod_pkg::sample_t width,
  output logic period_start,
  output logic sync,
  output logic pwm_out
);

  logic [mod_pkg::CARRIER_WIDTH-1:0] cnt;
  logic [mod_pkg::SAMPLE_WIDTH-1:0] pending_width;
  logic [mod_pkg::SAMPLE_WIDTH-1:0] latched_width;

  assign period_start = cnt == mod_pkg::CARRIER_LAST;
  assign sync = period_start;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cnt <= '0;
      pending_width <= '0;
      latched_width <= '0;
    end else begin
      cnt <= period_start ? '0 : cnt + 1'b1;
      if (width.valid) pending_width <= width.value;
      // a width arriving right on the boundary still wins
      if (period_start) begin
        latched_width <= width.valid ? width.value : pending_width;
      end
    end
  end

  // high for the first latched_width cycles of the period
  assign pwm_out = cnt < latched_width;

endmodule

// ==== hdl/ultrasound_top.sv ====
`timescale 1ns/1ps
module ultrasound_top (
  input logic CPU_CKIO,
  input logic rst_n,
  memory_bus_if.target bus,
  output logic sync,
  output logic pwm_out
);

  mod_pkg::mod_settings_t settings;
  mod_pkg::sample_t mod_sample;
  mod_pkg::sample_t scaled_sample;
  mod_pkg::sample_t pulse_width;
  logic period_start;

  controller_regs u_controller_regs (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .bus(bus),
    .settings(settings)
  );

  mod_sampler u_mod_sampler (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .bus(bus),
    .settings(settings),
    .period_start(period_start),
    .sample(mod_sample)
  );

  intensity_scaler u_intensity_scaler (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .settings(settings),
    .sample_in(mod_sample),
    .sample_out(scaled_sample)
  );

  pulse_width_encoder u_pulse_width_encoder (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .bus(bus),
    .sample_in(scaled_sample),
    .width(pulse_width)
  );

  pwm_generator u_pwm_generator (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .width(pulse_width),
    .period_start(period_start),
    .sync(sync),
    .pwm_out(pwm_out)
  );

endmodule

// ==== src.f ====
hdl/bus_pkg.sv
hdl/mod_pkg.sv
hdl/memory_bus_if.sv
hdl/controller_regs.sv
hdl/mod_sampler.sv
hdl/intensity_scaler.sv
hdl/pulse_width_encoder.sv
hdl/pwm_generator.sv
hdl/ultrasound_top.sv
bench/sim_helper_bram.sv
bench/tb_top.sv
